// ==== common/rv32i_cfg.svh ====
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// architectural registers, x0 included
`define NUM_REGS 32

`endif

// ==== common/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // alu_add at zero so an all-zero word is a harmless add
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        alu_pass_b = 4'd10
    } alu_ops;

    typedef enum logic [1:0] {
        wb_alu      = 2'd0,
        wb_load     = 2'd1,
        wb_pc_plus4 = 2'd2
    } wb_sel_t;

    typedef struct packed {
        alu_ops    alu_op;
        logic      use_imm;       // operand b from imm
        logic      use_pc;        // operand a from pc
        rv32i_word imm;           // decoded once in ID
        logic      mem_read;
        logic      mem_write;
        logic      byte_access;   // lb, lbu, sb
        logic      load_unsigned;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jump;
        logic      load_regfile;
        logic [4:0] dest;
        wb_sel_t   wb_sel;
    } ctrl_word_t;

    // no strobes, no register write
    localparam ctrl_word_t ctrl_bubble = '0;

endpackage

`default_nettype wire

// ==== datapath.f ====
+incdir+common
common/rv32i_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/control_unit.sv
rtl/hazard_forward.sv
rtl/datapath.sv
dv/datapath_tb.sv

// ==== dv/datapath_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_cfg.svh"

module datapath_tb;

    localparam int num_tests    = 5;
    localparam int max_words    = 24;
    localparam int max_stores   = 8;
    localparam int mem_words    = 64;
    localparam int drain_cycles = 20;   // quiet time that catches late stray stores

    logic        clk;
    logic        reset;
    logic [31:0] inst_rdata;
    logic [31:0] inst_addr;
    logic        inst_read;
    logic        inst_resp;
    logic [31:0] data_rdata;
    logic        data_resp;
    logic [31:0] data_wdata;
    logic [31:0] data_addr;
    logic [3:0]  data_mbe;
    logic        data_read;
    logic        data_write;

    logic [31:0] imem [mem_words];
    logic [31:0] dmem [mem_words];

    // program table with the instruction words and the stores each program must issue
    logic [31:0] prog_mem    [num_tests][max_words];
    int          prog_len    [num_tests];
    logic [31:0] exp_addr    [num_tests][max_stores];
    logic [31:0] exp_data    [num_tests][max_stores];
    logic [3:0]  exp_mbe     [num_tests][max_stores];
    int          store_cnt   [num_tests];
    int          cycle_limit [num_tests];
    bit          use_delay   [num_tests];
    string       test_name   [num_tests];

    int seed;
    bit delay_mode;
    int cur_test;
    int stores_seen;
    int rst_edges;
    int total_cycles;
    int watchdog_limit;
    int checks;
    int errors;
    int test_errors;

    datapath DUT (
        .clk        (clk),
        .reset      (reset),
        .inst_rdata (inst_rdata),
        .inst_addr  (inst_addr),
        .inst_read  (inst_read),
        .inst_resp  (inst_resp),
        .data_rdata (data_rdata),
        .data_resp  (data_resp),
        .data_wdata (data_wdata),
        .data_addr  (data_addr),
        .data_mbe   (data_mbe),
        .data_read  (data_read),
        .data_write (data_write)
    );

    always #4 clk = ~clk;

    assign inst_rdata = imem[inst_addr[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    // RV32I encoders
    function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input int op, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(input int f3, input int rs1, input int rs2,
                                          input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                          input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_jal(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic add_word(input int t, input logic [31:0] w);
        prog_mem[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic add_store(input int t, input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] m);
        exp_addr[t][store_cnt[t]] = a;
        exp_data[t][store_cnt[t]] = d;
        exp_mbe[t][store_cnt[t]]  = m;
        store_cnt[t]++;
    endtask

    task automatic build_program_table();
        for (int t = 0; t < num_tests; t++) begin
            prog_len[t]  = 0;
            store_cnt[t] = 0;
            use_delay[t] = 1'b0;
        end
        test_name[0] = "alu chain";
        add_word(0, enc_i(7'h13, 0, 1, 0, 5));        // addi x1 = 5
        add_word(0, enc_i(7'h13, 0, 2, 1, 7));        // x2 = 12 from MEM
        add_word(0, enc_r(7'h00, 0, 3, 1, 2));        // add x3 = 17
        add_word(0, enc_r(7'h20, 0, 4, 3, 1));        // sub x4 = 12
        add_word(0, enc_s(2, 0, 4, 0));
        add_word(0, enc_lui(5, 20'h80000));
        add_word(0, enc_r(7'h20, 5, 6, 5, 1));        // sra by 5
        add_word(0, enc_r(7'h00, 5, 7, 5, 1));        // srl by 5
        add_word(0, enc_r(7'h00, 4, 8, 6, 7));        // xor
        add_word(0, enc_s(2, 0, 8, 4));
        add_word(0, enc_r(7'h00, 2, 9, 6, 1));        // slt with negative < 5
        add_word(0, enc_r(7'h00, 3, 10, 6, 1));       // sltu
        add_word(0, enc_r(7'h00, 6, 11, 9, 4));       // or
        add_word(0, enc_i(7'h13, 1, 12, 11, 4));      // slli 4
        add_word(0, enc_i(7'h13, 7, 13, 12, 12'h05f)); // andi
        add_word(0, enc_s(2, 0, 9, 8));
        add_word(0, enc_s(2, 0, 10, 12));
        add_word(0, enc_s(2, 0, 13, 16));
        add_word(0, enc_jal(0, 0));                   // halt loop
        add_store(0, 32'h00, 32'h0000_000c, 4'hf);
        add_store(0, 32'h04, 32'hf800_0000, 4'hf);
        add_store(0, 32'h08, 32'h0000_0001, 4'hf);
        add_store(0, 32'h0c, 32'h0000_0000, 4'hf);
        add_store(0, 32'h10, 32'h0000_0050, 4'hf);

        test_name[1] = "load use";
        add_word(1, enc_i(7'h13, 0, 1, 0, 100));
        add_word(1, enc_s(2, 0, 1, 32));
        add_word(1, enc_i(7'h13, 0, 2, 0, 23));
        add_word(1, enc_i(7'h03, 2, 3, 0, 32));       // lw x3
        add_word(1, enc_r(7'h00, 0, 4, 3, 2));        // uses x3 at once
        add_word(1, enc_s(2, 0, 4, 36));
        add_word(1, enc_i(7'h03, 2, 5, 0, 36));
        add_word(1, enc_s(2, 0, 5, 40));              // store data from a load
        add_word(1, enc_jal(0, 0));
        add_store(1, 32'h20, 32'd100, 4'hf);
        add_store(1, 32'h24, 32'd123, 4'hf);
        add_store(1, 32'h28, 32'd123, 4'hf);

        test_name[2] = "branch and jal";
        add_word(2, enc_i(7'h13, 0, 1, 0, 3));
        add_word(2, enc_i(7'h13, 0, 2, 0, 3));
        add_word(2, enc_b(0, 1, 2, 16));              // beq taken to 24
        add_word(2, enc_s(2, 0, 1, 64));
        add_word(2, enc_s(2, 0, 1, 68));
        add_word(2, enc_s(2, 0, 1, 72));
        add_word(2, enc_b(1, 1, 2, 16));              // bne not taken
        add_word(2, enc_i(7'h13, 0, 3, 0, 9));
        add_word(2, enc_s(2, 0, 3, 0));
        add_word(2, enc_jal(5, 16));                  // at 36 jumps to 52
        add_word(2, enc_s(2, 0, 1, 76));
        add_word(2, enc_s(2, 0, 1, 80));
        add_word(2, enc_s(2, 0, 1, 84));
        add_word(2, enc_s(2, 0, 5, 4));               // link value
        add_word(2, enc_i(7'h13, 0, 6, 0, 1));
        add_word(2, enc_b(1, 6, 0, 16));              // bne taken to 76
        add_word(2, enc_s(2, 0, 1, 88));
        add_word(2, enc_s(2, 0, 1, 92));
        add_word(2, enc_s(2, 0, 1, 96));
        add_word(2, enc_s(2, 0, 6, 8));
        add_word(2, enc_jal(0, 0));
        add_store(2, 32'h00, 32'd9, 4'hf);
        add_store(2, 32'h04, 32'd40, 4'hf);
        add_store(2, 32'h08, 32'd1, 4'hf);

        test_name[3] = "byte lanes";
        add_word(3, enc_i(7'h13, 0, 1, 0, 12'h09c));
        add_word(3, enc_s(0, 0, 1, 48));              // sb lane 0
        add_word(3, enc_s(0, 0, 1, 49));
        add_word(3, enc_i(7'h13, 0, 2, 0, 12'h035));
        add_word(3, enc_s(0, 0, 2, 50));
        add_word(3, enc_s(0, 0, 2, 51));              // sb lane 3
        add_word(3, enc_i(7'h03, 0, 3, 0, 49));       // lb
        add_word(3, enc_i(7'h03, 4, 4, 0, 49));       // lbu
        add_word(3, enc_s(2, 0, 3, 52));
        add_word(3, enc_s(2, 0, 4, 56));
        add_word(3, enc_i(7'h03, 0, 5, 0, 50));
        add_word(3, enc_s(2, 0, 5, 60));
        add_word(3, enc_i(7'h03, 2, 6, 0, 48));
        add_word(3, enc_s(2, 0, 6, 44));
        add_word(3, enc_jal(0, 0));
        add_store(3, 32'h30, 32'h9c9c_9c9c, 4'b0001);
        add_store(3, 32'h31, 32'h9c9c_9c9c, 4'b0010);
        add_store(3, 32'h32, 32'h3535_3535, 4'b0100);
        add_store(3, 32'h33, 32'h3535_3535, 4'b1000);
        add_store(3, 32'h34, 32'hffff_ff9c, 4'hf);
        add_store(3, 32'h38, 32'h0000_009c, 4'hf);
        add_store(3, 32'h3c, 32'h0000_0035, 4'hf);
        add_store(3, 32'h2c, 32'h3535_9c9c, 4'hf);

        // program 2 again under random memory latency
        test_name[4] = "branch and jal, random latency";
        use_delay[4] = 1'b1;
        prog_len[4]  = prog_len[2];
        store_cnt[4] = store_cnt[2];
        prog_mem[4]  = prog_mem[2];
        exp_addr[4]  = exp_addr[2];
        exp_data[4]  = exp_data[2];
        exp_mbe[4]   = exp_mbe[2];

        watchdog_limit = 20;
        for (int t = 0; t < num_tests; t++) begin
            cycle_limit[t] = 40 + 10 * prog_len[t];
            if (use_delay[t]) begin
                cycle_limit[t] = cycle_limit[t] * 4;
            end
            watchdog_limit += cycle_limit[t] + drain_cycles + 8;
        end
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_reset_state();
        checks += 3;
        assert (inst_addr === `RESET_PC) else begin
            $display("Fail at %0t ns: inst_addr expected %h got %h", $time, `RESET_PC,
                     inst_addr);
            note_error();
        end
        assert (data_read === 1'b0) else begin
            $display("Fail at %0t ns: data_read expected 0 got %b", $time, data_read);
            note_error();
        end
        assert (data_write === 1'b0) else begin
            $display("Fail at %0t ns: data_write expected 0 got %b", $time, data_write);
            note_error();
        end
    endtask

    task automatic check_fetch_strobe();
        checks++;
        assert (inst_read === 1'b1) else begin
            $display("Fail at %0t ns: inst_read expected 1 got %b", $time, inst_read);
            note_error();
        end
    endtask

    task automatic check_store();
        int k;
        k = stores_seen;
        for (int b = 0; b < 4; b++) begin
            if (data_mbe[b]) begin
                dmem[data_addr[7:2]][8*b +: 8] = data_wdata[8*b +: 8];
            end
        end
        if (k < store_cnt[cur_test]) begin
            checks += 3;
            assert (data_addr === exp_addr[cur_test][k]) else begin
                $display("Fail at %0t ns: data_addr expected %h got %h", $time,
                         exp_addr[cur_test][k], data_addr);
                note_error();
            end
            assert (data_wdata === exp_data[cur_test][k]) else begin
                $display("Fail at %0t ns: data_wdata expected %h got %h", $time,
                         exp_data[cur_test][k], data_wdata);
                note_error();
            end
            assert (data_mbe === exp_mbe[cur_test][k]) else begin
                $display("Fail at %0t ns: data_mbe expected %b got %b", $time,
                         exp_mbe[cur_test][k], data_mbe);
                note_error();
            end
        end else begin
            $display("Error at %0t ns: unexpected extra store of %h to address %h",
                     $time, data_wdata, data_addr);
            note_error();
        end
        stores_seen = k + 1;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic run_test(input int t);
        int cycles;
        cur_test    = t;
        delay_mode  = use_delay[t];
        stores_seen = 0;
        test_errors = 0;
        for (int i = 0; i < mem_words; i++) begin
            if (i < prog_len[t]) begin
                imem[i] = prog_mem[t][i];
            end else begin
                imem[i] = 32'h0;
            end
            dmem[i] = (i * 32'h0404_0404) ^ 32'ha5a5_a5a5;   // byte address based fill
        end
        apply_reset();
        cycles = 0;
        while (stores_seen < store_cnt[t] && cycles < cycle_limit[t]) begin
            @(posedge clk);
            cycles++;
        end
        if (stores_seen < store_cnt[t]) begin
            $display("Error: test %0d saw only %0d of %0d stores within %0d cycles",
                     t, stores_seen, store_cnt[t], cycle_limit[t]);
            note_error();
        end else begin
            repeat (drain_cycles) @(posedge clk);
        end
        $display("test %0d (%s): %0d stores, %0d errors", t, test_name[t], stores_seen,
                 test_errors);
    endtask

    // memory responses 1 ns after the edge
    always @(posedge clk) begin
        #1;
        if (delay_mode) begin
            inst_resp = ($random(seed) & 3) != 0;
            data_resp = ($random(seed) & 1) != 0;
        end else begin
            inst_resp = 1'b1;
            data_resp = 1'b1;
        end
    end

    always @(posedge clk) begin
        rst_edges <= reset ? rst_edges + 1 : 0;
    end

    always @(negedge clk) begin
        if (rst_edges > 0) begin
            check_reset_state();   // in reset and the first cycle after it
        end
        if (reset === 1'b0) begin
            check_fetch_strobe();
        end
        if (!reset && data_write === 1'b1 && data_resp === 1'b1) begin
            check_store();
        end
    end

    always @(posedge clk) begin
        total_cycles++;
        if (total_cycles > watchdog_limit) begin
            $display("Timeout: run went past %0d cycles", watchdog_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        inst_resp    = 1'b0;
        data_resp    = 1'b0;
        seed         = 5;
        delay_mode   = 1'b0;
        cur_test     = 0;
        stores_seen  = 0;
        total_cycles = 0;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = 32'h0;
            dmem[i] = 32'h0;
        end
        build_program_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d checks run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  rv32i_pkg::alu_ops    aluop,
    input  rv32i_pkg::rv32i_word a,
    input  rv32i_pkg::rv32i_word b,
    output rv32i_pkg::rv32i_word f,
    output logic                 eq
);

    logic [4:0] shamt;

    assign shamt = b[4:0];
    assign eq    = (a == b);   // raw operands, for beq and bne

    always_comb begin
        case (aluop)
            rv32i_pkg::alu_add:    f = a + b;
            rv32i_pkg::alu_sub:    f = a - b;
            rv32i_pkg::alu_and:    f = a & b;
            rv32i_pkg::alu_or:     f = a | b;
            rv32i_pkg::alu_xor:    f = a ^ b;
            rv32i_pkg::alu_slt:    f = {31'b0, $signed(a) < $signed(b)};
            rv32i_pkg::alu_sltu:   f = {31'b0, a < b};
            rv32i_pkg::alu_sll:    f = a << shamt;
            rv32i_pkg::alu_srl:    f = a >> shamt;
            rv32i_pkg::alu_sra:    f = $unsigned($signed(a) >>> shamt);
            rv32i_pkg::alu_pass_b: f = b;   // lui
            default:               f = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  rv32i_pkg::rv32i_word  instr,
    output rv32i_pkg::ctrl_word_t ctrl
);

    rv32i_pkg::rv32i_opcode opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rv32i_pkg::rv32i_word   imm_i;
    rv32i_pkg::rv32i_word   imm_s;
    rv32i_pkg::rv32i_word   imm_b;
    rv32i_pkg::rv32i_word   imm_u;
    rv32i_pkg::rv32i_word   imm_j;
    rv32i_pkg::alu_ops      arith_op;   // shared by reg and imm forms
    logic                   arith_ok;
    logic                   valid;

    assign opcode = rv32i_pkg::rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == rv32i_pkg::op_reg && funct7[5]) ?
                                rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
            3'b001:  arith_op = rv32i_pkg::alu_sll;
            3'b010:  arith_op = rv32i_pkg::alu_slt;
            3'b011:  arith_op = rv32i_pkg::alu_sltu;
            3'b100:  arith_op = rv32i_pkg::alu_xor;
            3'b101:  arith_op = funct7[5] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            3'b110:  arith_op = rv32i_pkg::alu_or;
            default: arith_op = rv32i_pkg::alu_and;
        endcase
        arith_ok = 1'b1;
        // funct7 only means something for reg ops and shifts
        if (opcode == rv32i_pkg::op_reg || funct3 == 3'b001 || funct3 == 3'b101) begin
            arith_ok = (funct7 == 7'h00) ||
                       (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        end
    end

    always_comb begin
        ctrl      = rv32i_pkg::ctrl_bubble;
        valid     = 1'b1;
        ctrl.dest = instr[11:7];
        case (opcode)
            rv32i_pkg::op_lui: begin
                ctrl.alu_op       = rv32i_pkg::alu_pass_b;
                ctrl.use_imm      = 1'b1;
                ctrl.imm          = imm_u;
                ctrl.load_regfile = 1'b1;
            end
            rv32i_pkg::op_jal: begin
                ctrl.use_pc       = 1'b1;   // alu forms the target
                ctrl.use_imm      = 1'b1;
                ctrl.imm          = imm_j;
                ctrl.is_jump      = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.wb_sel       = rv32i_pkg::wb_pc_plus4;
            end
            rv32i_pkg::op_br: begin
                ctrl.use_pc    = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_b;
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                valid          = (funct3[2:1] == 2'b00);   // beq, bne only
            end
            rv32i_pkg::op_load: begin
                ctrl.use_imm       = 1'b1;
                ctrl.imm           = imm_i;
                ctrl.mem_read      = 1'b1;
                ctrl.byte_access   = (funct3[1:0] == 2'b00);
                ctrl.load_unsigned = funct3[2];
                ctrl.load_regfile  = 1'b1;
                ctrl.wb_sel        = rv32i_pkg::wb_load;
                valid = (funct3 == 3'b000) || (funct3 == 3'b010) || (funct3 == 3'b100);
            end
            rv32i_pkg::op_store: begin
                ctrl.use_imm     = 1'b1;
                ctrl.imm         = imm_s;
                ctrl.mem_write   = 1'b1;
                ctrl.byte_access = (funct3 == 3'b000);
                valid            = (funct3 == 3'b000) || (funct3 == 3'b010);
            end
            rv32i_pkg::op_imm: begin
                ctrl.alu_op       = arith_op;
                ctrl.use_imm      = 1'b1;
                ctrl.imm          = imm_i;
                ctrl.load_regfile = 1'b1;
                valid             = arith_ok;
            end
            rv32i_pkg::op_reg: begin
                ctrl.alu_op       = arith_op;
                ctrl.load_regfile = 1'b1;
                valid             = arith_ok;
            end
            default: valid = 1'b0;
        endcase
        if (!valid) begin
            ctrl = rv32i_pkg::ctrl_bubble;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_cfg.svh"

module datapath (
    input  logic                 clk,
    input  logic                 reset,

    input  rv32i_pkg::rv32i_word inst_rdata,
    output rv32i_pkg::rv32i_word inst_addr,
    output logic                 inst_read,
    input  logic                 inst_resp,

    input  rv32i_pkg::rv32i_word data_rdata,
    input  logic                 data_resp,
    output rv32i_pkg::rv32i_word data_wdata,
    output rv32i_pkg::rv32i_word data_addr,
    output logic [3:0]           data_mbe,
    output logic                 data_read,
    output logic                 data_write
);

    rv32i_pkg::rv32i_word  pc;
    logic                  advance;      // global stall when low
    logic                  taken;        // branch or jal resolved in MEM
    logic                  load_stall;
    logic [1:0]            fwd_a;
    logic [1:0]            fwd_b;

    rv32i_pkg::rv32i_word  ir_id;
    rv32i_pkg::rv32i_word  pc_id;
    rv32i_pkg::ctrl_word_t ctrl_id;
    rv32i_pkg::rv32i_word  rs1_val;
    rv32i_pkg::rv32i_word  rs2_val;
    logic [4:0]            rs1_id;
    logic [4:0]            rs2_id;

    rv32i_pkg::ctrl_word_t ctrl_ex;
    rv32i_pkg::rv32i_word  pc_ex;
    rv32i_pkg::rv32i_word  rs1_val_ex;
    rv32i_pkg::rv32i_word  rs2_val_ex;
    logic [4:0]            rs1_ex;
    logic [4:0]            rs2_ex;
    rv32i_pkg::rv32i_word  fwd_a_val;
    rv32i_pkg::rv32i_word  fwd_b_val;
    rv32i_pkg::rv32i_word  alu_a;
    rv32i_pkg::rv32i_word  alu_b;
    rv32i_pkg::rv32i_word  alu_out;
    logic                  br_eq;

    rv32i_pkg::ctrl_word_t ctrl_mem;
    rv32i_pkg::rv32i_word  pc_mem;
    rv32i_pkg::rv32i_word  alu_out_mem;
    rv32i_pkg::rv32i_word  store_val_mem;
    logic                  br_eq_mem;
    logic [1:0]            lane_mem;
    logic                  data_req;
    logic                  data_done;    // access already answered, waiting on fetch
    rv32i_pkg::rv32i_word  rdata_hold;

    rv32i_pkg::ctrl_word_t ctrl_wb;
    rv32i_pkg::rv32i_word  pc_wb;
    rv32i_pkg::rv32i_word  alu_out_wb;
    rv32i_pkg::rv32i_word  rdata_wb;
    logic [7:0]            load_byte;
    rv32i_pkg::rv32i_word  load_val;
    rv32i_pkg::rv32i_word  wb_val;

    function automatic rv32i_pkg::rv32i_word fwd_mux(
        input logic [1:0]           sel,
        input rv32i_pkg::rv32i_word reg_val,
        input rv32i_pkg::rv32i_word mem_val,
        input rv32i_pkg::rv32i_word wb_v
    );
        case (sel)
            2'b01:   return mem_val;
            2'b10:   return wb_v;
            default: return reg_val;
        endcase
    endfunction

    assign data_read  = ctrl_mem.mem_read && !data_done;
    assign data_write = ctrl_mem.mem_write && !data_done;
    assign data_req   = data_read || data_write;
    assign advance    = inst_resp && (!data_req || data_resp);
    assign taken      = ctrl_mem.is_jump ||
                        (ctrl_mem.is_branch && (br_eq_mem != ctrl_mem.branch_ne));

    assign inst_addr = pc;
    assign inst_read = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (advance) begin
            if (taken) begin
                pc <= alu_out_mem;   // target formed by the EX alu
            end else if (!load_stall) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ir_id <= '0;             // zero decodes to a bubble
        end else if (advance && (taken || !load_stall)) begin
            ir_id <= taken ? '0 : inst_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !load_stall) begin
            pc_id <= pc;
        end
    end

    assign rs1_id = ir_id[19:15];
    assign rs2_id = ir_id[24:20];

    control_unit u_control (
        .instr (ir_id),
        .ctrl  (ctrl_id)
    );

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .load  (ctrl_wb.load_regfile),
        .dest  (ctrl_wb.dest),
        .src_a (rs1_id),
        .src_b (rs2_id),
        .in    (wb_val),
        .reg_a (rs1_val),
        .reg_b (rs2_val)
    );

    hazard_forward u_hazard (
        .rs1_ex      (rs1_ex),
        .rs2_ex      (rs2_ex),
        .dest_ex     (ctrl_ex.dest),
        .dest_mem    (ctrl_mem.dest),
        .dest_wb     (ctrl_wb.dest),
        .rs1_id      (rs1_id),
        .rs2_id      (rs2_id),
        .write_mem   (ctrl_mem.load_regfile),
        .write_wb    (ctrl_wb.load_regfile),
        .mem_read_ex (ctrl_ex.mem_read),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .load_stall  (load_stall)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_ex <= rv32i_pkg::ctrl_bubble;
        end else if (advance) begin
            ctrl_ex <= (taken || load_stall) ? rv32i_pkg::ctrl_bubble : ctrl_id;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pc_ex      <= pc_id;
            rs1_val_ex <= rs1_val;
            rs2_val_ex <= rs2_val;
            rs1_ex     <= rs1_id;
            rs2_ex     <= rs2_id;
        end
    end

    assign fwd_a_val = fwd_mux(fwd_a, rs1_val_ex, alu_out_mem, wb_val);
    assign fwd_b_val = fwd_mux(fwd_b, rs2_val_ex, alu_out_mem, wb_val);
    assign alu_a     = ctrl_ex.use_pc ? pc_ex : fwd_a_val;
    assign alu_b     = ctrl_ex.use_imm ? ctrl_ex.imm : fwd_b_val;

    alu u_alu (
        .aluop (ctrl_ex.alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_out),
        .eq    ()
    );

    // second copy only for the register compare of beq and bne
    alu u_cmp (
        .aluop (rv32i_pkg::alu_sub),
        .a     (fwd_a_val),
        .b     (fwd_b_val),
        .f     (),
        .eq    (br_eq)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_mem <= rv32i_pkg::ctrl_bubble;
        end else if (advance) begin
            ctrl_mem <= taken ? rv32i_pkg::ctrl_bubble : ctrl_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pc_mem        <= pc_ex;
            alu_out_mem   <= alu_out;
            store_val_mem <= fwd_b_val;
            br_eq_mem     <= br_eq;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_done <= 1'b0;
        end else if (advance) begin
            data_done <= 1'b0;
        end else if (data_req && data_resp) begin
            data_done <= 1'b1;   // fetch still pending, drop the strobe
        end
    end

    always_ff @(posedge clk) begin
        if (data_read && data_resp) begin
            rdata_hold <= data_rdata;
        end
    end

    assign data_addr  = alu_out_mem;
    assign lane_mem   = alu_out_mem[1:0];
    assign data_wdata = ctrl_mem.byte_access ? {4{store_val_mem[7:0]}} : store_val_mem;

    always_comb begin
        if (!data_req) begin
            data_mbe = 4'b0000;
        end else if (ctrl_mem.byte_access) begin
            data_mbe = 4'b0001 << lane_mem;
        end else begin
            data_mbe = 4'b1111;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_wb <= rv32i_pkg::ctrl_bubble;
        end else if (advance) begin
            ctrl_wb <= ctrl_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pc_wb      <= pc_mem;
            alu_out_wb <= alu_out_mem;
            rdata_wb   <= data_done ? rdata_hold : data_rdata;
        end
    end

    assign load_byte = rdata_wb[{alu_out_wb[1:0], 3'b000} +: 8];

    always_comb begin
        if (ctrl_wb.byte_access) begin
            load_val = {{24{load_byte[7] & ~ctrl_wb.load_unsigned}}, load_byte};
        end else begin
            load_val = rdata_wb;
        end
        case (ctrl_wb.wb_sel)
            rv32i_pkg::wb_load:     wb_val = load_val;
            rv32i_pkg::wb_pc_plus4: wb_val = pc_wb + 32'd4;   // jal link
            default:                wb_val = alu_out_wb;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/hazard_forward.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_forward (
    input  logic [4:0] rs1_ex,
    input  logic [4:0] rs2_ex,
    input  logic [4:0] dest_ex,
    input  logic [4:0] dest_mem,
    input  logic [4:0] dest_wb,
    input  logic [4:0] rs1_id,
    input  logic [4:0] rs2_id,
    input  logic       write_mem,
    input  logic       write_wb,
    input  logic       mem_read_ex,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b,
    output logic       load_stall
);

    // 00 regfile, 01 MEM stage alu result, 10 WB value
    function automatic logic [1:0] pick_src(
        input logic [4:0] rs,
        input logic [4:0] d_mem,
        input logic       w_mem,
        input logic [4:0] d_wb,
        input logic       w_wb
    );
        if (rs == 5'd0) begin
            return 2'b00;
        end
        if (w_mem && d_mem == rs) begin
            return 2'b01;   // youngest result wins
        end
        if (w_wb && d_wb == rs) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    assign fwd_a = pick_src(rs1_ex, dest_mem, write_mem, dest_wb, write_wb);
    assign fwd_b = pick_src(rs2_ex, dest_mem, write_mem, dest_wb, write_wb);

    // load data only exists after MEM, so hold the consumer one advance
    assign load_stall = mem_read_ex && (dest_ex != 5'd0) &&
                        ((dest_ex == rs1_id) || (dest_ex == rs2_id));

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_cfg.svh"

module regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic [4:0]           dest,
    input  logic [4:0]           src_a,
    input  logic [4:0]           src_b,
    input  rv32i_pkg::rv32i_word in,
    output rv32i_pkg::rv32i_word reg_a,
    output rv32i_pkg::rv32i_word reg_b
);

    rv32i_pkg::rv32i_word regs [`NUM_REGS];
    logic                 wr_en;

    assign wr_en = load && (dest != 5'd0);   // x0 never written

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[dest] <= in;
        end
    end

    // write-through so ID sees the WB value of the same cycle
    assign reg_a = (src_a == 5'd0) ? '0 : (wr_en && dest == src_a) ? in : regs[src_a];
    assign reg_b = (src_b == 5'd0) ? '0 : (wr_en && dest == src_b) ? in : regs[src_b];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f datapath.f --top-module datapath_tb -o sim_datapath

./obj_dir/sim_datapath | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
